/* logic/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// pc after reset and the bubble instruction (addi x0, x0, 0)
`define FETCH_RESET_PC  32'h0000_0000
`define FETCH_NOP       32'h0000_0013

// control-flow opcodes seen by the mini decoder
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011

// branch condition codes
`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_BLT          3'b100
`define F3_BGE          3'b101
`define F3_BLTU         3'b110
`define F3_BGEU         3'b111

// link registers, ra and t0
`define REG_RA          5'd1
`define REG_T0          5'd5

// predictor sizing, RAS depth must be a power of two
`define BHT_IDX_BITS    4
`define CTR_WEAK_NT     2'b01
`define RAS_DEPTH       4

`endif

/* logic/fetch_pkg.sv */
package fetch_pkg;

    // data word, also used for pc and instruction
    typedef logic [31:0] word_t;

    // architectural register number
    typedef logic [4:0] reg_addr_t;

    // branch condition field of a B-type instruction
    typedef logic [2:0] func3_t;

    // source of a branch or jalr operand
    typedef enum logic [1:0] {
        FWD_REG    = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2
    } fwd_sel_t;

    // two-bit saturating counter
    // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
    typedef logic [1:0] ctr_t;

endpackage

/* logic/fetch_decode.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_decode (
    input  fetch_pkg::word_t     instr_i,

    output logic                 jal_o,
    output logic                 jalr_o,
    output logic                 branch_o,

    output fetch_pkg::reg_addr_t rs1_o,
    output fetch_pkg::reg_addr_t rs2_o,
    output fetch_pkg::reg_addr_t rd_o,
    output fetch_pkg::func3_t    func3_o,
    output fetch_pkg::word_t     imm_o
);

    logic [6:0] opcode;

    assign opcode = instr_i[6:0];

    // register fields sit at fixed positions for every format
    assign rs1_o   = instr_i[19:15];
    assign rs2_o   = instr_i[24:20];
    assign rd_o    = instr_i[11:7];
    assign func3_o = instr_i[14:12];

    always_comb begin
        jal_o    = 1'b0;
        jalr_o   = 1'b0;
        branch_o = 1'b0;
        imm_o    = '0;

        case (opcode)
            `OPC_JAL: begin
                jal_o = 1'b1;
                // J-type
                imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            `OPC_JALR: begin
                jalr_o = 1'b1;
                // I-type
                imm_o  = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            `OPC_BRANCH: begin
                branch_o = 1'b1;
                // B-type
                imm_o    = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            end
            default: begin
                // not a control-flow instruction
                imm_o = '0;
            end
        endcase
    end

endmodule

/* logic/fetch_hazard.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_hazard (
    input  fetch_pkg::reg_addr_t rs1_i,
    input  fetch_pkg::reg_addr_t rs2_i,
    input  fetch_pkg::reg_addr_t rd_i,
    input  fetch_pkg::reg_addr_t id_rd_i,
    input  fetch_pkg::reg_addr_t id_ex_rd_i,
    input  fetch_pkg::reg_addr_t ex_mem_rd_i,
    input  fetch_pkg::reg_addr_t mem_wb_rd_i,

    input  logic                 id_wr_i,
    input  logic                 id_ex_wr_i,
    input  logic                 ex_mem_wr_i,
    input  logic                 mem_wb_wr_i,
    input  logic                 ex_mem_rd_mem_i,

    input  logic                 jal_i,
    input  logic                 jalr_i,
    input  logic                 branch_i,
    input  logic                 ras_empty_i,
    input  logic                 stall_i,

    output fetch_pkg::fwd_sel_t  fwd1_sel_o,
    output fetch_pkg::fwd_sel_t  fwd2_sel_o,
    output logic                 bht_use_o,
    output logic                 ras_use_o,
    output logic                 ras_push_o,
    output logic                 ras_pop_o,
    output logic                 self_stall_o
);

    import fetch_pkg::*;

    logic rs1_busy;
    logic rs2_busy;
    logic rd_link;
    logic rs1_link;

    // value still being produced in ID, ID/EX or by a load in EX/MEM
    function automatic logic rs_busy(input reg_addr_t rs);
        if (rs == '0) begin
            return 1'b0;
        end
        return (id_wr_i && rs == id_rd_i) ||
               (id_ex_wr_i && rs == id_ex_rd_i) ||
               (ex_mem_rd_mem_i && rs == ex_mem_rd_i);
    endfunction

    function automatic fwd_sel_t rs_fwd(input reg_addr_t rs);
        if (rs != '0 && ex_mem_wr_i && !ex_mem_rd_mem_i && rs == ex_mem_rd_i) begin
            return FWD_EX_MEM;
        end else if (rs != '0 && mem_wb_wr_i && rs == mem_wb_rd_i) begin
            return FWD_MEM_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        rs1_busy   = rs_busy(rs1_i);
        rs2_busy   = rs_busy(rs2_i);
        fwd1_sel_o = rs_fwd(rs1_i);
        fwd2_sel_o = rs_fwd(rs2_i);

        rd_link  = (rd_i == `REG_RA) || (rd_i == `REG_T0);
        rs1_link = (rs1_i == `REG_RA) || (rs1_i == `REG_T0);

        bht_use_o    = branch_i && (rs1_busy || rs2_busy);
        ras_use_o    = jalr_i && rs1_busy && !ras_empty_i;
        self_stall_o = jalr_i && rs1_busy && ras_empty_i;

        // stack only moves when this fetch actually advances
        ras_push_o = (jal_i || jalr_i) && rd_link && !stall_i && !self_stall_o;
        ras_pop_o  = jalr_i && rs1_link && rd_i == '0 && !ras_empty_i &&
                     !stall_i && !self_stall_o;

        // decoder flags are one-hot, so a stall never comes from a jal or branch
        assert (!self_stall_o || (jalr_i && !jal_i && !branch_i));
    end

endmodule

/* logic/branch_predictor.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             rst_n_i,

    input  fetch_pkg::word_t pc_i,

    input  logic             resolve_valid_i,
    input  fetch_pkg::word_t resolve_pc_i,
    input  logic             resolve_taken_i,

    input  logic             push_i,
    input  logic             pop_i,
    input  fetch_pkg::word_t push_data_i,

    output logic             pred_taken_o,
    output fetch_pkg::word_t ras_top_o,
    output logic             ras_empty_o
);

    import fetch_pkg::*;

    localparam int BHT_ENTRIES = 1 << `BHT_IDX_BITS;
    localparam int RAS_PTR_W   = $clog2(`RAS_DEPTH);
    localparam logic [RAS_PTR_W:0] RAS_FULL = `RAS_DEPTH;

    ////////////////////////////////////////////////////////////////////////////
    // bimodal table

    ctr_t bht_q [BHT_ENTRIES];

    logic [`BHT_IDX_BITS-1:0] rd_idx;
    logic [`BHT_IDX_BITS-1:0] wr_idx;
    ctr_t                     wr_ctr;

    assign rd_idx       = pc_i[`BHT_IDX_BITS+1:2];
    assign wr_idx       = resolve_pc_i[`BHT_IDX_BITS+1:2];
    assign pred_taken_o = bht_q[rd_idx][1];

    always_comb begin
        wr_ctr = bht_q[wr_idx];
        if (resolve_taken_i && wr_ctr != 2'b11) begin
            wr_ctr = wr_ctr + 2'b01;
        end else if (!resolve_taken_i && wr_ctr != 2'b00) begin
            wr_ctr = wr_ctr - 2'b01;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht_q[i] <= `CTR_WEAK_NT;
            end
        end else if (resolve_valid_i) begin
            bht_q[wr_idx] <= wr_ctr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // return address stack

    word_t                ras_mem [`RAS_DEPTH];
    logic [RAS_PTR_W-1:0] ras_ptr_q;
    logic [RAS_PTR_W-1:0] ras_ptr_inc;
    logic [RAS_PTR_W:0]   ras_cnt_q;

    // top entry, wraps around so a full push drops the oldest
    assign ras_ptr_inc = ras_ptr_q + 1'b1;
    assign ras_top_o   = ras_mem[ras_ptr_q];
    assign ras_empty_o = (ras_cnt_q == '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ras_ptr_q <= '0;
            ras_cnt_q <= '0;
        end else if (push_i && !pop_i) begin
            ras_ptr_q <= ras_ptr_inc;
            if (ras_cnt_q != RAS_FULL) begin
                ras_cnt_q <= ras_cnt_q + 1'b1;
            end
        end else if (pop_i && !push_i) begin
            ras_ptr_q <= ras_ptr_q - 1'b1;
            ras_cnt_q <= ras_cnt_q - 1'b1;
        end
    end

    // push and pop together replace the top
    always_ff @(posedge clk) begin
        if (push_i && pop_i) begin
            ras_mem[ras_ptr_q] <= push_data_i;
        end else if (push_i) begin
            ras_mem[ras_ptr_inc] <= push_data_i;
        end
    end

    // hazard logic must never request a pop from an empty stack
    assert property (@(posedge clk) disable iff (!rst_n_i) pop_i |-> !ras_empty_o);

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,

    output fetch_pkg::word_t     rom_addr_o,
    input  fetch_pkg::word_t     instr_i,
    output fetch_pkg::word_t     instr_o,

    output fetch_pkg::word_t     pc_plus4_o,
    output fetch_pkg::word_t     target_o,
    output logic                 taken_o,

    output fetch_pkg::reg_addr_t rs1_addr_o,
    output fetch_pkg::reg_addr_t rs2_addr_o,
    input  fetch_pkg::word_t     rs1_data_i,
    input  fetch_pkg::word_t     rs2_data_i,

    input  fetch_pkg::word_t     ex_mem_result_i,
    input  fetch_pkg::word_t     mem_wb_result_i,

    input  fetch_pkg::reg_addr_t id_rd_i,
    input  fetch_pkg::reg_addr_t id_ex_rd_i,
    input  fetch_pkg::reg_addr_t ex_mem_rd_i,
    input  fetch_pkg::reg_addr_t mem_wb_rd_i,

    input  logic                 id_wr_i,
    input  logic                 id_ex_wr_i,
    input  logic                 ex_mem_wr_i,
    input  logic                 mem_wb_wr_i,
    input  logic                 id_ex_rd_mem_i,
    input  logic                 ex_mem_rd_mem_i,

    input  logic                 stall_i,
    input  logic                 flush_i,
    input  fetch_pkg::word_t     rollback_pc_i,

    input  logic                 resolve_valid_i,
    input  fetch_pkg::word_t     resolve_pc_i,
    input  logic                 resolve_taken_i
);

    import fetch_pkg::*;

    word_t     pc_q;
    word_t     pc_next;
    word_t     pc_plus4;

    logic      jal;
    logic      jalr;
    logic      branch;
    reg_addr_t rd;
    func3_t    func3;
    word_t     imm;

    fwd_sel_t  fwd1_sel;
    fwd_sel_t  fwd2_sel;
    logic      bht_use;
    logic      ras_use;
    logic      ras_push;
    logic      ras_pop;
    logic      ras_empty;
    logic      self_stall;
    logic      pred_taken;
    word_t     ras_top;

    word_t     op1;
    word_t     op2;
    logic      cmp_taken;
    logic      br_taken;
    logic      jump;
    word_t     jump_base;
    word_t     jump_sum;
    word_t     jump_target;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_data);
        case (sel)
            FWD_EX_MEM: return ex_mem_result_i;
            FWD_MEM_WB: return mem_wb_result_i;
            default:    return reg_data;
        endcase
    endfunction

    assign rom_addr_o = pc_q;
    assign instr_o    = self_stall ? `FETCH_NOP : instr_i;
    assign pc_plus4   = pc_q + 32'd4;
    assign pc_plus4_o = pc_plus4;

    fetch_decode u_decode (
        .instr_i  (instr_i),
        .jal_o    (jal),
        .jalr_o   (jalr),
        .branch_o (branch),
        .rs1_o    (rs1_addr_o),
        .rs2_o    (rs2_addr_o),
        .rd_o     (rd),
        .func3_o  (func3),
        .imm_o    (imm)
    );

    // a load sitting in ID/EX always blocks its destination
    fetch_hazard u_hazard (
        .rs1_i           (rs1_addr_o),
        .rs2_i           (rs2_addr_o),
        .rd_i            (rd),
        .id_rd_i         (id_rd_i),
        .id_ex_rd_i      (id_ex_rd_i),
        .ex_mem_rd_i     (ex_mem_rd_i),
        .mem_wb_rd_i     (mem_wb_rd_i),
        .id_wr_i         (id_wr_i),
        .id_ex_wr_i      (id_ex_wr_i | id_ex_rd_mem_i),
        .ex_mem_wr_i     (ex_mem_wr_i),
        .mem_wb_wr_i     (mem_wb_wr_i),
        .ex_mem_rd_mem_i (ex_mem_rd_mem_i),
        .jal_i           (jal),
        .jalr_i          (jalr),
        .branch_i        (branch),
        .ras_empty_i     (ras_empty),
        .stall_i         (stall_i),
        .fwd1_sel_o      (fwd1_sel),
        .fwd2_sel_o      (fwd2_sel),
        .bht_use_o       (bht_use),
        .ras_use_o       (ras_use),
        .ras_push_o      (ras_push),
        .ras_pop_o       (ras_pop),
        .self_stall_o    (self_stall)
    );

    branch_predictor u_predictor (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pc_i            (pc_q),
        .resolve_valid_i (resolve_valid_i),
        .resolve_pc_i    (resolve_pc_i),
        .resolve_taken_i (resolve_taken_i),
        .push_i          (ras_push),
        .pop_i           (ras_pop),
        .push_data_i     (pc_plus4),
        .pred_taken_o    (pred_taken),
        .ras_top_o       (ras_top),
        .ras_empty_o     (ras_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // operands and branch direction

    always_comb begin
        op1 = fwd_mux(fwd1_sel, rs1_data_i);
        op2 = fwd_mux(fwd2_sel, rs2_data_i);
    end

    always_comb begin
        case (func3)
            `F3_BEQ:  cmp_taken = (op1 == op2);
            `F3_BNE:  cmp_taken = (op1 != op2);
            `F3_BLT:  cmp_taken = ($signed(op1) < $signed(op2));
            `F3_BGE:  cmp_taken = ($signed(op1) >= $signed(op2));
            `F3_BLTU: cmp_taken = (op1 < op2);
            `F3_BGEU: cmp_taken = (op1 >= op2);
            default:  cmp_taken = 1'b0;
        endcase
    end

    assign br_taken = bht_use ? pred_taken : cmp_taken;
    assign jump     = jal || jalr || (branch && br_taken);
    assign taken_o  = jump;

    ////////////////////////////////////////////////////////////////////////////
    // jump target and next pc

    // jalr base comes from the RAS when rs1 is still in flight
    assign jump_base   = !jalr ? pc_q : (ras_use ? ras_top : op1);
    assign jump_sum    = jump_base + imm;
    assign jump_target = jalr ? {jump_sum[31:1], 1'b0} : jump_sum;
    assign target_o    = jump_target;

    always_comb begin
        if (flush_i) begin
            pc_next = rollback_pc_i;
        end else if (stall_i || self_stall) begin
            pc_next = pc_q;
        end else if (jump) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // rollback pcs and jump targets from the rest of the core stay aligned
    assert property (@(posedge clk) disable iff (!rst_n_i) pc_q[1:0] == 2'b00);

endmodule

/* tests/fetch_stage_tb.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_stage_tb;

    import fetch_pkg::*;

    localparam int CYCLES       = 4000;
    localparam int RESET_CYCLES = 16;

    logic      clk;
    logic      rst_n_i;
    word_t     instr_i, rom_addr_o, instr_o, pc_plus4_o, target_o;
    word_t     rs1_data_i, rs2_data_i, ex_mem_result_i, mem_wb_result_i;
    word_t     rollback_pc_i, resolve_pc_i;
    reg_addr_t rs1_addr_o, rs2_addr_o, id_rd_i, id_ex_rd_i, ex_mem_rd_i, mem_wb_rd_i;
    logic      taken_o, id_wr_i, id_ex_wr_i, ex_mem_wr_i, mem_wb_wr_i;
    logic      id_ex_rd_mem_i, ex_mem_rd_mem_i, stall_i, flush_i;
    logic      resolve_valid_i, resolve_taken_i;

    // instruction ROM and register file, both combinational
    word_t rom [256];
    word_t regs [32];

    // predictor and pc model
    word_t m_pc;
    ctr_t  m_bht [16];
    word_t m_ras [`RAS_DEPTH];
    int    m_cnt;

    logic [31:0] rng;
    bit          checking;
    int          n_checks, pc_errs, instr_errs, taken_errs, gaps;
    int          target_errs, plus4_errs, raddr_errs;
    int          n_bht, n_ras, n_hold;

    assign instr_i    = rom[rom_addr_o[9:2]];
    assign rs1_data_i = regs[rs1_addr_o];
    assign rs2_data_i = regs[rs2_addr_o];

    fetch_stage uut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // small values now and then so that beq and bne both fire
    function automatic word_t data_word(input logic [31:0] r);
        return r[0] ? (r & 32'h0000_000c) : (r & ~32'h3);
    endfunction

    // targets stay word aligned: imm bit 1 is forced low
    function automatic word_t make_instr(input logic [31:0] r);
        word_t w;
        w = xorshift(r ^ 32'h5bd1_e995);
        w[19:15] = {2'b00, r[2:0]};
        w[24:20] = {2'b00, r[5:3]};
        w[11:7]  = {2'b00, r[8:6]};
        case (r[31:29])
            3'd0, 3'd1: begin
                w[6:0]   = `OPC_BRANCH;
                w[14:12] = (r[11:9] inside {3'd2, 3'd3}) ? `F3_BEQ : r[11:9];
                w[8]     = 1'b0;
            end
            3'd2: begin
                w[6:0] = `OPC_JAL;
                w[21]  = 1'b0;
            end
            3'd3, 3'd4: begin
                w[6:0]   = `OPC_JALR;
                w[14:12] = 3'b000;
                w[21]    = 1'b0;
                if (r[12]) begin
                    // return through ra or t0
                    w[11:7]  = 5'd0;
                    w[19:15] = r[13] ? `REG_T0 : `REG_RA;
                end
            end
            default: w[6:0] = 7'b0010011;
        endcase
        return w;
    endfunction

    function automatic logic src_busy(input reg_addr_t rs);
        return rs != 5'd0 && ((id_wr_i && rs == id_rd_i) || (id_ex_wr_i && rs == id_ex_rd_i) ||
                              (ex_mem_rd_mem_i && rs == ex_mem_rd_i));
    endfunction

    function automatic word_t src_value(input reg_addr_t rs);
        if (rs != 5'd0 && ex_mem_wr_i && !ex_mem_rd_mem_i && rs == ex_mem_rd_i) begin
            return ex_mem_result_i;
        end
        if (rs != 5'd0 && mem_wb_wr_i && rs == mem_wb_rd_i) begin
            return mem_wb_result_i;
        end
        return regs[rs];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference next pc

    function automatic word_t ref_next_pc(input word_t pc, input word_t instr,
                                          output logic exp_taken, output word_t exp_instr,
                                          output word_t exp_target,
                                          output logic push, output logic pop,
                                          output logic used_bht, output logic used_ras,
                                          output logic self_st);
        logic [6:0] opc;
        reg_addr_t  rs1, rs2, rd;
        word_t      imm, a, b, base, sum, tgt;
        logic       is_jal, is_jalr, is_br, b1, b2, cmp, dir, hold;
        opc     = instr[6:0];
        rs1     = instr[19:15];
        rs2     = instr[24:20];
        rd      = instr[11:7];
        is_jal  = opc == `OPC_JAL;
        is_jalr = opc == `OPC_JALR;
        is_br   = opc == `OPC_BRANCH;
        case (opc)
            `OPC_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            `OPC_JALR:   imm = {{20{instr[31]}}, instr[31:20]};
            `OPC_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default:     imm = '0;
        endcase
        b1 = src_busy(rs1);
        b2 = src_busy(rs2);
        a  = src_value(rs1);
        b  = src_value(rs2);
        case (instr[14:12])
            `F3_BEQ:  cmp = a == b;
            `F3_BNE:  cmp = a != b;
            `F3_BLT:  cmp = $signed(a) < $signed(b);
            `F3_BGE:  cmp = $signed(a) >= $signed(b);
            `F3_BLTU: cmp = a < b;
            default:  cmp = a >= b;
        endcase
        used_bht = is_br && (b1 || b2);
        used_ras = is_jalr && b1 && m_cnt > 0;
        self_st  = is_jalr && b1 && m_cnt == 0;
        dir      = used_bht ? m_bht[pc[5:2]][1] : cmp;
        base     = used_ras ? m_ras[m_cnt-1] : a;
        sum      = base + imm;
        tgt      = is_jalr ? {sum[31:1], 1'b0} : pc + imm;
        hold     = stall_i || self_st;
        push     = (is_jal || is_jalr) && (rd == `REG_RA || rd == `REG_T0) && !hold;
        pop      = is_jalr && (rs1 == `REG_RA || rs1 == `REG_T0) && rd == 5'd0 &&
                   m_cnt > 0 && !hold;
        exp_taken  = is_jal || is_jalr || (is_br && dir);
        exp_instr  = self_st ? `FETCH_NOP : instr;
        exp_target = tgt;
        return flush_i ? rollback_pc_i : (hold ? pc : (exp_taken ? tgt : pc + 32'd4));
    endfunction

    task automatic drive_cycle();
        logic [31:0] r;
        rng             = xorshift(rng);
        r               = rng;
        id_rd_i         = {2'b00, r[2:0]};
        id_ex_rd_i      = {2'b00, r[5:3]};
        ex_mem_rd_i     = {2'b00, r[8:6]};
        mem_wb_rd_i     = {2'b00, r[11:9]};
        id_wr_i         = r[12] & r[13];
        id_ex_wr_i      = r[14] & r[15];
        id_ex_rd_mem_i  = id_ex_wr_i & r[16];
        ex_mem_wr_i     = r[17];
        ex_mem_rd_mem_i = ex_mem_wr_i & r[18] & r[19];
        mem_wb_wr_i     = r[20];
        stall_i         = r[23:21] == 3'd0;
        flush_i         = r[27:24] == 4'd0;
        resolve_valid_i = r[29:28] == 2'd0;
        resolve_taken_i = r[30];
        rng             = xorshift(rng);
        ex_mem_result_i = data_word(rng);
        rollback_pc_i   = rng & 32'h0000_03fc;
        rng             = xorshift(rng);
        mem_wb_result_i = data_word(rng);
        resolve_pc_i    = (rng >> 16) & 32'h0000_03fc;
        rng             = xorshift(rng);
        if (rng[4:0] != 5'd0) begin
            regs[rng[4:0]] = data_word(rng >> 5);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checker, half a cycle after the inputs change

    always @(posedge clk) begin
        word_t nxt, ei, et, ins;
        logic  tk, psh, pp, ub, ur, ss;
        if (checking) begin
            n_checks++;
            ins = rom[m_pc[9:2]];
            assert (rom_addr_o == m_pc) else begin
                $display("ERR %0t: rom_addr_o %h, expected %h", $time, rom_addr_o, m_pc);
                pc_errs++;
            end
            assert (pc_plus4_o == m_pc + 32'd4) else begin
                $display("ERR %0t: pc_plus4_o %h, expected %h", $time, pc_plus4_o,
                         m_pc + 32'd4);
                plus4_errs++;
            end
            assert (rs1_addr_o == ins[19:15] && rs2_addr_o == ins[24:20]) else begin
                $display("ERR %0t: rs1/rs2 address %0d %0d, expected %0d %0d", $time,
                         rs1_addr_o, rs2_addr_o, ins[19:15], ins[24:20]);
                raddr_errs++;
            end
            nxt = ref_next_pc(m_pc, ins, tk, ei, et, psh, pp, ub, ur, ss);
            assert (instr_o == ei) else begin
                $display("ERR %0t: instr_o %h, expected %h", $time, instr_o, ei);
                instr_errs++;
            end
            assert (taken_o == tk) else begin
                $display("ERR %0t: taken_o %b, expected %b at pc %h", $time, taken_o, tk, m_pc);
                taken_errs++;
            end
            assert (target_o == et) else begin
                $display("ERR %0t: target_o %h, expected %h at pc %h", $time, target_o, et,
                         m_pc);
                target_errs++;
            end
            n_bht  += int'(ub);
            n_ras  += int'(ur);
            n_hold += int'(ss);
            if (resolve_valid_i && resolve_taken_i && m_bht[resolve_pc_i[5:2]] != 2'b11) begin
                m_bht[resolve_pc_i[5:2]] += 2'b01;
            end else if (resolve_valid_i && !resolve_taken_i &&
                         m_bht[resolve_pc_i[5:2]] != 2'b00) begin
                m_bht[resolve_pc_i[5:2]] -= 2'b01;
            end
            if (pp) begin
                m_cnt--;
            end
            if (psh) begin
                if (m_cnt == `RAS_DEPTH) begin
                    // oldest entry falls out
                    for (int i = 1; i < `RAS_DEPTH; i++) begin
                        m_ras[i-1] = m_ras[i];
                    end
                    m_cnt--;
                end
                m_ras[m_cnt] = m_pc + 32'd4;
                m_cnt++;
            end
            m_pc = nxt;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #((CYCLES + RESET_CYCLES + 50) * 4);
        $display("watchdog expired before the test sequence finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rng = 32'ha5a07ec7;
        for (int i = 0; i < 256; i++) begin
            rng    = xorshift(rng);
            rom[i] = make_instr(rng);
        end
        for (int i = 0; i < 32; i++) begin
            rng     = xorshift(rng);
            regs[i] = (i == 0) ? '0 : data_word(rng);
        end
        rst_n_i         = 1'b0;
        {id_rd_i, id_ex_rd_i, ex_mem_rd_i, mem_wb_rd_i} = '0;
        {id_wr_i, id_ex_wr_i, ex_mem_wr_i, mem_wb_wr_i} = '0;
        {id_ex_rd_mem_i, ex_mem_rd_mem_i, stall_i, flush_i} = '0;
        {resolve_valid_i, resolve_taken_i} = '0;
        {ex_mem_result_i, mem_wb_result_i, rollback_pc_i, resolve_pc_i} = '0;
        m_pc  = `FETCH_RESET_PC;
        m_cnt = 0;
        for (int i = 0; i < 16; i++) begin
            m_bht[i] = `CTR_WEAK_NT;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i  = 1'b1;
        checking = 1'b1;
        repeat (CYCLES) begin
            drive_cycle();
            @(negedge clk);
        end
        #1;
        checking = 1'b0;
        if (n_bht == 0) begin
            $display("no branch was predicted by the counter table");
            gaps++;
        end
        if (n_ras == 0) begin
            $display("no jalr took its target from the RAS");
            gaps++;
        end
        if (n_hold == 0) begin
            $display("no jalr stalled on an empty RAS");
            gaps++;
        end
        $write("checks %0d  pc errors %0d  instr errors %0d  taken errors %0d",
               n_checks, pc_errs, instr_errs, taken_errs);
        $display("  target errors %0d  pc+4 errors %0d  address errors %0d  gaps %0d",
                 target_errs, plus4_errs, raddr_errs, gaps);
        if (pc_errs + instr_errs + taken_errs + target_errs + plus4_errs + raddr_errs +
            gaps == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_decode.sv
logic/fetch_hazard.sv
logic/branch_predictor.sv
logic/fetch_stage.sv
tests/fetch_stage_tb.sv

/* Makefile */
TOP := fetch_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
